// ==== src.f ====
+incdir+sim
rtl/rvPkg.sv
rtl/aluIf.sv
rtl/alu.sv
rtl/registerFile.sv
rtl/addressAdder.sv
rtl/loadStoreUnit.sv
rtl/coreControl.sv
rtl/femtoCore.sv
sim/femtoCoreTb.sv

// ==== Bender.yml ====
package:
  name: femto_core

sources:
  - rtl/rvPkg.sv
  - rtl/aluIf.sv
  - rtl/alu.sv
  - rtl/registerFile.sv
  - rtl/addressAdder.sv
  - rtl/loadStoreUnit.sv
  - rtl/coreControl.sv
  - rtl/femtoCore.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/femtoCoreTb.sv

// ==== sim/refModel.svh ====
// *********************************************************************
// Instruction-level reference model
// *********************************************************************
logic [31:0] modelMem [1024];   // Own copy of program and data
logic [31:0] xr [32];           // Architectural registers
logic [31:0] expAddr [$];       // Expected store trace, oldest first
logic [31:0] expData [$];       // Store data already moved to its lanes
logic [3:0]  expMask [$];

function automatic logic [31:0] byteLanes(input logic [3:0] m);
   return {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
endfunction

// RV32I integer rules, alt selects SUB or SRA
function automatic logic [31:0] aluResult(logic [2:0] f3, logic [31:0] a, logic [31:0] b,
                                          logic alt);
   case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return {31'b0, $signed(a) < $signed(b)};
      3'd3: return {31'b0, a < b};
      3'd4: return a ^ b;
      3'd5: begin
         if (alt) return $signed(a) >>> b[4:0];   // Sign fill
         return a >> b[4:0];
      end
      3'd6: return a | b;
      default: return a & b;
   endcase
endfunction

function automatic logic [31:0] loadExtract(logic [2:0] f3, logic [31:0] word, logic [1:0] off);
   logic [31:0] w;
   w = word >> (8 * off);                   // Addressed byte down to lane 0
   case (f3)
      3'd0: return {{24{w[7]}}, w[7:0]};    // LB
      3'd1: return {{16{w[15]}}, w[15:0]};  // LH
      3'd4: return {24'b0, w[7:0]};         // LBU
      3'd5: return {16'b0, w[15:0]};        // LHU
      default: return w;
   endcase
endfunction

task automatic runModel();
   logic [31:0] pc, ins, a, b, res, ea, next;
   logic [3:0]  mask;
   logic        wr;
   logic        stop;
   pc   = '0;
   stop = 1'b0;
   while (!stop) begin
      ins  = modelMem[pc[11:2]];
      a    = xr[ins[19:15]];
      b    = xr[ins[24:20]];
      next = pc + 4;
      wr   = 1'b1;
      res  = '0;
      case (ins[6:2])
         opLui:    res = {ins[31:12], 12'b0};
         opAuipc:  res = (pc + {ins[31:12], 12'b0}) & 32'h00FF_FFFF;  // 24-bit sum
         opJal: begin
            res  = pc + 4;
            next = pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
         end
         opJalr: begin
            res  = pc + 4;
            next = a + {{20{ins[31]}}, ins[31:20]};
         end
         opBranch: begin
            wr = 1'b0;
            case (ins[14:12])
               3'd0: wr = (a == b);
               3'd1: wr = (a != b);
               3'd4: wr = ($signed(a) < $signed(b));
               3'd5: wr = ($signed(a) >= $signed(b));
               3'd6: wr = (a < b);
               default: wr = (a >= b);
            endcase
            if (wr) next = pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            wr = 1'b0;                                   // Taken flag reused, no rd
         end
         opLoad: begin
            ea  = (a + {{20{ins[31]}}, ins[31:20]}) & 32'h00FF_FFFF;
            res = loadExtract(ins[14:12], modelMem[ea[11:2]], ea[1:0]);
         end
         opStore: begin
            wr   = 1'b0;
            ea   = (a + {{20{ins[31]}}, ins[31:25], ins[11:7]}) & 32'h00FF_FFFF;
            mask = (ins[13] ? 4'b1111 : ins[12] ? 4'b0011 : 4'b0001) << ea[1:0];
            expAddr.push_back(ea);
            expData.push_back(b << (8 * ea[1:0]));
            expMask.push_back(mask);
            if (!(ea[23] | ea[22])) begin                 // Device writes skip memory
               modelMem[ea[11:2]] = (modelMem[ea[11:2]] & ~byteLanes(mask)) |
                                    ((b << (8 * ea[1:0])) & byteLanes(mask));
            end
            stop = (ea == doneAddr);
         end
         opAluImm: res = aluResult(ins[14:12], a, {{20{ins[31]}}, ins[31:20]},
                                   ins[30] & (ins[14:12] == 3'd5));
         opAluReg: res = aluResult(ins[14:12], a, b, ins[30]);
         default: begin
            wr   = 1'b0;
            stop = 1'b1;                                 // Not a generated opcode
         end
      endcase
      if (wr && ins[11:7] != 5'd0) xr[ins[11:7]] = res;
      pc = next & 32'h00FF_FFFF;
   end
endtask

// ==== sim/femtoCoreTb.sv ====
`timescale 1ns/10ps

module femtoCoreTb import rvPkg::*; ();

   localparam logic [31:0] doneAddr   = 32'h0080_0000;  // Device address of the last store
   localparam int          stepCycles = 60;             // Watchdog budget per instruction

   logic        clk;
   logic        reset;
   logic [31:0] memAddr;
   logic [31:0] memWdata;
   logic [3:0]  memWmask;
   logic [31:0] memRdata;
   logic        memRstrb;
   logic        memRbusy;
   logic        memWbusy;

   logic [31:0] mem [1024];          // Program from 0, data window 0x400..0x7FF
   integer      seed = 32'h67065a90;
   int          progLen;
   int          valueErrors;
   int          otherErrors;
   logic        done;
   logic        devicePending;       // Device write not yet released by memWbusy

   `include "refModel.svh"

   femtoCore u_femtoCore (.*);

   // *******************************************************************
   // Instruction encoders and program generator
   // *******************************************************************
   function automatic logic [31:0] iType(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                         logic [4:0] rd, logic [4:0] op);
      return {imm, rs1, f3, rd, op, 2'b11};   // R type too, funct7 and rs2 as imm
   endfunction

   function automatic logic [31:0] sType(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                         logic [2:0] f3);
      return {imm[11:5], rs2, rs1, f3, imm[4:0], opStore, 2'b11};
   endfunction

   function automatic logic [31:0] bType(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                         logic [2:0] f3);
      return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opBranch, 2'b11};
   endfunction

   function automatic logic [31:0] uType(logic [19:0] imm, logic [4:0] rd, logic [4:0] op);
      return {imm, rd, op, 2'b11};
   endfunction

   function automatic logic [31:0] jType(logic [20:0] imm, logic [4:0] rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opJal, 2'b11};
   endfunction

   function automatic int randBelow(input int n);
      return $unsigned($random(seed)) % n;
   endfunction

   function automatic logic [4:0] randReg();
      return 5'(1 + randBelow(29));          // x30, x31 hold the window bases
   endfunction

   function automatic logic [11:0] offsetFor(input logic [1:0] size);
      return 12'h400 + (12'(randBelow(1024)) & ~12'((1 << size) - 1));  // Aligned
   endfunction

   task automatic emit(input logic [31:0] w);
      mem[progLen] = w;
      progLen++;
   endtask

   task automatic storeReg(input logic [4:0] r);
      emit(sType(offsetFor(2'd2), r, randBelow(2) ? 5'd31 : 5'd30, 3'd2));  // SW, maybe device
   endtask

   task automatic buildProgram();
      int          i;
      int          k;
      int          sel;
      logic [4:0]  rd, rs1;
      logic [2:0]  f3;
      logic        alt;
      logic [4:0]  lastOp;
      for (i = 0; i < 1024; i++) begin
         mem[i] = 32'(i) * 32'h9E37_79B1 ^ 32'h5A5A_0F0F;  // Hash of the word address
      end
      progLen = 0;
      for (i = 1; i < 30; i++) begin
         emit(uType(20'($random(seed)), 5'(i), opLui));
      end
      emit(uType({8'($random(seed)), 12'h000}, 5'd30, opLui));  // Data window base
      emit(uType({8'($random(seed)), 12'h400}, 5'd31, opLui));  // Device window base
      while (progLen < 226) begin
         rd  = randReg();
         rs1 = randReg();
         f3  = 3'(randBelow(8));
         alt = (f3 == 3'd0 || f3 == 3'd5) && randBelow(2) == 1;  // SUB, SRA, SRAI
         k   = randBelow(2);                                     // Skip length - 1
         case (randBelow(8))
            0: emit(iType({1'b0, alt, 5'b0, randReg()}, rs1, f3, rd, opAluReg));
            1: emit(iType((f3 == 3'd1 || f3 == 3'd5) ? {1'b0, alt, 5'b0, 5'(randBelow(32))}
                                                      : 12'($random(seed)), rs1, f3, rd, opAluImm));
            2: emit(uType(20'($random(seed)), rd, randBelow(2) ? opAuipc : opLui));
            3: begin
               sel = randBelow(5);                              // LB LH LW LBU LHU
               f3  = (sel > 2) ? 3'(sel + 1) : 3'(sel);
               emit(iType(offsetFor(f3[1:0]), 5'd30, f3, rd, opLoad));
            end
            4: begin
               sel = randBelow(3);                              // SB SH SW
               emit(sType(offsetFor(2'(sel)), randReg(), randBelow(2) ? 5'd31 : 5'd30, 3'(sel)));
            end
            5: begin
               sel = randBelow(6);
               emit(bType(13'(8 + 4 * k), randBelow(4) == 0 ? rs1 : randReg(), rs1,
                          (sel < 2) ? 3'(sel) : 3'(sel + 2)));
            end
            6: emit(jType(21'(8 + 4 * k), rd));
            default: begin
               emit(uType(20'd0, rs1, opAuipc));                // Base for JALR
               emit(iType(12'(12 + 4 * k), rs1, 3'd0, rd, opJalr));
            end
         endcase
         lastOp = mem[progLen - 1][6:2];
         if (lastOp inside {opBranch, opJal, opJalr}) begin
            repeat (k + 1) storeReg(randReg());                 // Skipped when taken
         end
         if (lastOp != opBranch) storeReg(rd);                  // Observe the result
      end
      emit(uType(20'h00800, 5'd29, opLui));
      emit(sType(12'h000, 5'd1, 5'd29, 3'd2));                   // Final store to doneAddr
      emit(jType(21'd0, 5'd0));                                  // Park
   endtask

   // *******************************************************************
   // Clock, memory model and store checker
   // *******************************************************************
   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   task automatic checkWrite();
      logic [31:0] lanes;
      assert (expAddr.size() > 0) else begin
         otherErrors++;
         $display("Write to %h after the end of the expected store trace", memAddr);
      end
      if (expAddr.size() == 0) return;
      lanes = byteLanes(memWmask);
      assert (memAddr === expAddr[0]) else begin
         valueErrors++;
         $display("** Error memAddr: got %h, expected %h", memAddr, expAddr[0]);
      end
      assert (memWmask === expMask[0]) else begin
         valueErrors++;
         $display("** Error memWmask: got %h, expected %h", memWmask, expMask[0]);
      end
      assert ((memWdata & lanes) === (expData[0] & lanes)) else begin
         valueErrors++;
         $display("** Error memWdata: got %h, expected %h", memWdata & lanes,
                  expData[0] & lanes);
      end
      if (!(memAddr[23] | memAddr[22])) begin
         mem[memAddr[11:2]] <= (mem[memAddr[11:2]] & ~lanes) | (memWdata & lanes);
      end
      if (memAddr == doneAddr) done = 1'b1;
      void'(expAddr.pop_front());
      void'(expData.pop_front());
      void'(expMask.pop_front());
   endtask

   always @(posedge clk) begin : memoryModel
      logic stall;
      stall = reset && (randBelow(4) == 0);
      // One cycle read latency, word is garbage while the read is still busy
      memRdata <= stall ? ~mem[memAddr[11:2]] : mem[memAddr[11:2]];
      memRbusy <= stall;
      if (reset) begin
         memWbusy <= (randBelow(4) == 0);
         assert (!(memRstrb && devicePending)) else begin
            otherErrors++;
            $display("Read strobe raised before memWbusy released a device write");
         end
         if (!memWbusy) devicePending = 1'b0;
         if (memWmask != 4'b0000) begin
            if (memAddr[23] | memAddr[22]) devicePending = 1'b1;
            checkWrite();
         end
      end
   end

   // *******************************************************************
   // Sequence and watchdog
   // *******************************************************************
   initial begin
      reset    <= 1'b0;
      memRdata <= '0;
      memRbusy <= 1'b0;
      memWbusy <= 1'b0;
      valueErrors   = 0;
      otherErrors   = 0;
      done          = 1'b0;
      devicePending = 1'b0;
      buildProgram();
      modelMem = mem;
      runModel();
      @(posedge clk);
      @(posedge clk);
      assert (memRstrb === 1'b0 && memWmask === 4'b0000) else begin
         otherErrors++;
         $display("Read strobe or write mask active during reset");
      end
      reset <= 1'b1;
      wait (done);
      repeat (4) @(posedge clk);
      assert (expAddr.size() == 0) else begin
         otherErrors++;
         $display("%0d expected stores never appeared", expAddr.size());
      end
      $display("Errors: %0d value mismatches, %0d other failures", valueErrors, otherErrors);
      if (valueErrors == 0 && otherErrors == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

   initial begin
      #1;                                    // Program length known after time zero
      repeat (progLen * stepCycles) @(posedge clk);
      otherErrors++;
      $display("Timeout: no store to the done address within %0d cycles",
               progLen * stepCycles);
      $display("Errors: %0d value mismatches, %0d other failures", valueErrors, otherErrors);
      $display("Testbench failed");
      $finish;
   end

endmodule

// ==== rtl/femtoCore.sv ====
`timescale 1ns/10ps

module femtoCore import rvPkg::*; (
   input  logic            clk,
   input  logic            reset,      // Synchronous, active low
   output logic [xlen-1:0] memAddr,
   output logic [xlen-1:0] memWdata,
   output logic [3:0]      memWmask,
   input  logic [xlen-1:0] memRdata,
   output logic            memRstrb,
   input  logic            memRbusy,
   input  logic            memWbusy
);

   logic                     readEnable;
   logic [regIndexWidth-1:0] rdIndex;
   logic                     writeEnable;
   logic [xlen-1:0]          writeData;
   logic [xlen-1:0]          rs1Data;
   logic [xlen-1:0]          rs2Data;
   logic                     useRs1Base;
   logic [addrWidth-1:0]     pc;
   logic [addrWidth-1:0]     immValue;
   logic [addrWidth-1:0]     addrSum;
   logic [xlen-1:0]          loadValue;
   logic                     storeStrobe;
   funct3T                   funct3;

   aluIf aluBus ();

   coreControl u_coreControl (
      .clk, .reset, .aluBus(aluBus.ctrl),
      .memRdata, .memRbusy, .memWbusy, .memRstrb, .memAddr,
      .readEnable, .rdIndex, .writeEnable, .writeData, .rs1Data, .rs2Data,
      .useRs1Base, .pc, .immValue, .addrSum,
      .loadValue, .storeStrobe, .funct3
   );

   alu u_alu (.clk, .aluBus(aluBus.unit));

   // Source indices come straight off the fetched word
   registerFile u_registerFile (
      .clk, .readEnable,
      .rs1Index(memRdata[19:15]), .rs2Index(memRdata[24:20]),
      .rs1Data, .rs2Data, .writeEnable, .rdIndex, .writeData
   );

   addressAdder u_addressAdder (
      .clk, .capture(aluBus.start), .useRs1Base, .pc,
      .rs1Low(rs1Data[addrWidth-1:0]), .imm(immValue), .addrSum
   );

   loadStoreUnit u_loadStoreUnit (
      .addrLow(memAddr[1:0]), .funct3, .memRdata, .rs2Data, .storeStrobe,
      .loadValue, .memWdata, .memWmask
   );

endmodule

// ==== rtl/coreControl.sv ====
`timescale 1ns/10ps

module coreControl import rvPkg::*; (
   input  logic                     clk,
   input  logic                     reset,
   aluIf.ctrl                       aluBus,
   // Memory bus
   input  logic [xlen-1:0]          memRdata,
   input  logic                     memRbusy,
   input  logic                     memWbusy,
   output logic                     memRstrb,
   output logic [xlen-1:0]          memAddr,
   // Register file
   output logic                     readEnable,
   output logic [regIndexWidth-1:0] rdIndex,
   output logic                     writeEnable,
   output logic [xlen-1:0]          writeData,
   input  logic [xlen-1:0]          rs1Data,
   input  logic [xlen-1:0]          rs2Data,
   // Address adder
   output logic                     useRs1Base,
   output logic [addrWidth-1:0]     pc,
   output logic [addrWidth-1:0]     immValue,
   input  logic [addrWidth-1:0]     addrSum,
   // Load/store unit
   input  logic [xlen-1:0]          loadValue,
   output logic                     storeStrobe,
   output funct3T                   funct3
);

   stateT                state;
   logic [31:2]          instr;     // Bits 1:0 are always 11 in RV32I
   logic [addrWidth-1:0] addrReg;   // Drives the bus address
   logic [addrWidth-1:0] pcPlus4;
   opcodeT               opcode;
   logic                 isLoad, isAluImm, isStore, isAluReg;
   logic                 isBranch, isJalr, isJal, isAlu;
   logic [xlen-1:0]      uImm, iImm, sImm, bImm, jImm;
   logic                 jumpOrTaken;

   // *******************************************************************
   // Decode
   // *******************************************************************
   assign opcode   = opcodeT'(instr[6:2]);
   assign isLoad   = (opcode == opLoad);
   assign isAluImm = (opcode == opAluImm);
   assign isStore  = (opcode == opStore);
   assign isAluReg = (opcode == opAluReg);
   assign isBranch = (opcode == opBranch);
   assign isJalr   = (opcode == opJalr);
   assign isJal    = (opcode == opJal);
   assign isAlu    = isAluImm | isAluReg;

   assign rdIndex = instr[11:7];
   assign funct3  = instr[14:12];

   // The five immediate formats
   assign uImm = {instr[31:12], 12'b0};
   assign iImm = {{21{instr[31]}}, instr[30:20]};
   assign sImm = {{21{instr[31]}}, instr[30:25], instr[11:7]};
   assign bImm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
   assign jImm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

   // *******************************************************************
   // Datapath controls
   // *******************************************************************
   assign aluBus.in1        = rs1Data;
   assign aluBus.in2        = (isAluReg | isBranch) ? rs2Data : iImm;
   assign aluBus.start      = (state == addrAndAlu) | !reset;  // Reset clears the shift count
   assign aluBus.isAluOp    = isAlu;
   assign aluBus.funct3     = funct3;
   assign aluBus.subtract   = instr[30] & instr[5];  // ADDI uses bit 30 as immediate
   assign aluBus.arithShift = instr[30];

   assign useRs1Base = isLoad | isStore | isJalr;
   always_comb begin
      case (opcode)
         opJal:    immValue = jImm[addrWidth-1:0];
         opAuipc:  immValue = uImm[addrWidth-1:0];
         opStore:  immValue = sImm[addrWidth-1:0];
         opBranch: immValue = bImm[addrWidth-1:0];
         default:  immValue = iImm[addrWidth-1:0];  // Loads and JALR
      endcase
   end

   assign pcPlus4     = pc + addrWidth'(4);
   assign jumpOrTaken = isJal | isJalr | (isBranch & aluBus.predicate);

   // Write-back source
   always_comb begin
      case (opcode)
         opLui:              writeData = uImm;
         opAluImm, opAluReg: writeData = aluBus.result;
         opAuipc:            writeData = {{(xlen-addrWidth){1'b0}}, addrSum};
         opJal, opJalr:      writeData = {{(xlen-addrWidth){1'b0}}, pcPlus4};  // Return address
         default:            writeData = loadValue;
      endcase
   end

   // Final value lands on the cycle that leaves waitAluOrMem
   assign writeEnable = !(isBranch | isStore) & ((state == execute) | (state == waitAluOrMem));
   assign readEnable  = (state == waitInstr) & !memRbusy;
   assign memRstrb    = (state == fetchInstr) | (state == loadData);
   assign storeStrobe = (state == storeData);
   assign memAddr     = {{(xlen-addrWidth){1'b0}}, addrReg};

   // *******************************************************************
   // Sequencer
   // *******************************************************************
   always_ff @(posedge clk) begin
      if (!reset) begin
         state <= waitAluOrMem;  // Leave once nothing is busy
         pc    <= resetAddr;
         instr <= '0;            // Decodes as a load into x0
      end else begin
         case (state)
            fetchInstr: state <= waitInstr;
            waitInstr: begin
               if (!memRbusy) begin
                  instr <= memRdata[31:2];
                  state <= fetchRegs;
               end
            end
            fetchRegs:  state <= addrAndAlu;
            addrAndAlu: state <= execute;
            execute: begin
               pc      <= jumpOrTaken ? addrSum : pcPlus4;
               addrReg <= (isLoad | isStore | jumpOrTaken) ? addrSum : pcPlus4;
               if (isStore) begin
                  state <= storeData;
               end else if (isLoad) begin
                  state <= loadData;
               end else if (aluBus.busy) begin
                  state <= waitAluOrMem;  // Shift still running
               end else begin
                  state <= fetchInstr;
               end
            end
            loadData: state <= waitAluOrMem;
            storeData: begin
               state   <= ioSpace(addrReg) ? waitAluOrMem : fetchInstr;  // Device waits on busy
               addrReg <= pc;
            end
            waitAluOrMem: begin
               if (!aluBus.busy && !memRbusy && !memWbusy) begin
                  addrReg <= pc;
                  state   <= fetchInstr;
               end
            end
            default: state <= waitAluOrMem;
         endcase
      end
   end

endmodule

// ==== rtl/loadStoreUnit.sv ====
`timescale 1ns/10ps

module loadStoreUnit import rvPkg::*; (
   input  logic [1:0]      addrLow,      // Byte offset in the word
   input  funct3T          funct3,
   input  logic [xlen-1:0] memRdata,
   input  logic [xlen-1:0] rs2Data,
   input  logic            storeStrobe,  // High in storeData only
   output logic [xlen-1:0] loadValue,
   output logic [xlen-1:0] memWdata,
   output logic [3:0]      memWmask
);

   logic        byteAccess;
   logic        halfAccess;
   logic [15:0] loadHalf;
   logic [7:0]  loadByte;
   logic        loadSign;
   logic [3:0]  storeMask;

   // funct3[1:0] is 00 byte, 01 halfword, 10 word
   assign byteAccess = (funct3[1:0] == 2'b00);
   assign halfAccess = (funct3[1:0] == 2'b01);

   // *******************************************************************
   // Loads
   // *******************************************************************
   assign loadHalf  = addrLow[1] ? memRdata[31:16] : memRdata[15:0];
   assign loadByte  = addrLow[0] ? loadHalf[15:8] : loadHalf[7:0];
   assign loadSign  = !funct3[2] & (byteAccess ? loadByte[7] : loadHalf[15]);  // LBU, LHU
   assign loadValue = byteAccess ? {{24{loadSign}}, loadByte} :
                      halfAccess ? {{16{loadSign}}, loadHalf} : memRdata;

   // *******************************************************************
   // Stores, low lanes copied so the mask alone picks the target bytes
   // *******************************************************************
   assign memWdata[7:0]   = rs2Data[7:0];
   assign memWdata[15:8]  = addrLow[0] ? rs2Data[7:0] : rs2Data[15:8];
   assign memWdata[23:16] = addrLow[1] ? rs2Data[7:0] : rs2Data[23:16];
   assign memWdata[31:24] = addrLow[0] ? rs2Data[7:0] :
                            addrLow[1] ? rs2Data[15:8] : rs2Data[31:24];

   always_comb begin
      if (byteAccess) begin
         storeMask = 4'b0001 << addrLow;
      end else if (halfAccess) begin
         storeMask = addrLow[1] ? 4'b1100 : 4'b0011;
      end else begin
         storeMask = 4'b1111;
      end
   end

   assign memWmask = {4{storeStrobe}} & storeMask;

endmodule

// ==== rtl/addressAdder.sv ====
`timescale 1ns/10ps

module addressAdder import rvPkg::*; (
   input  logic                 clk,
   input  logic                 capture,      // High in addrAndAlu
   input  logic                 useRs1Base,   // Loads, stores and JALR
   input  logic [addrWidth-1:0] pc,
   input  logic [addrWidth-1:0] rs1Low,
   input  logic [addrWidth-1:0] imm,          // Immediate already picked by control
   output logic [addrWidth-1:0] addrSum
);

   logic [addrWidth-1:0] base;

   assign base = useRs1Base ? rs1Low : pc;  // rs1+imm or PC+imm

   // Held through execute and the memory states
   always_ff @(posedge clk) begin
      if (capture) begin
         addrSum <= base + imm;
      end
   end

endmodule

// ==== rtl/registerFile.sv ====
`timescale 1ns/10ps

module registerFile import rvPkg::*; (
   input  logic                     clk,
   input  logic                     readEnable,   // Instruction word is being latched
   input  logic [regIndexWidth-1:0] rs1Index,
   input  logic [regIndexWidth-1:0] rs2Index,
   output logic [xlen-1:0]          rs1Data,
   output logic [xlen-1:0]          rs2Data,
   input  logic                     writeEnable,
   input  logic [regIndexWidth-1:0] rdIndex,
   input  logic [xlen-1:0]          writeData
);

   logic [xlen-1:0] regs [2**regIndexWidth];

   // Both sources read straight from the fetched word
   always_ff @(posedge clk) begin
      if (readEnable) begin
         rs1Data <= regs[rs1Index];
         rs2Data <= regs[rs2Index];
      end
   end

   // x0 stays unwritten, so it reads back whatever it powered up to
   // only if never touched; writes to it are dropped here
   always_ff @(posedge clk) begin
      if (writeEnable && (rdIndex != '0)) begin
         regs[rdIndex] <= writeData;
      end
   end

endmodule

// ==== rtl/alu.sv ====
`timescale 1ns/10ps

module alu import rvPkg::*; (
   input logic clk,
   aluIf.unit  aluBus
);

   logic [xlen-1:0] acc;            // Result register, also the shift register
   logic [4:0]      shamt;          // Remaining shift steps
   logic [xlen-1:0] sum;
   logic [xlen:0]   diff;           // One subtraction for SUB and every compare
   logic            lessSigned;
   logic            lessUnsigned;
   logic            equal;

   assign sum          = aluBus.in1 + aluBus.in2;
   assign diff         = {1'b1, ~aluBus.in2} + {1'b0, aluBus.in1} + 33'd1;
   assign lessUnsigned = diff[xlen];   // Borrow out
   assign equal        = (diff[xlen-1:0] == '0);
   // Signs differ means in1 is less exactly when it is negative
   assign lessSigned   = (aluBus.in1[xlen-1] ^ aluBus.in2[xlen-1]) ?
                         aluBus.in1[xlen-1] : diff[xlen];

   assign aluBus.result = acc;
   assign aluBus.busy   = |shamt;

   // *******************************************************************
   // Arithmetic, logic and serial shifts
   // *******************************************************************
   always_ff @(posedge clk) begin
      if (aluBus.start) begin
         shamt <= '0;                              // Only shifts reload it below
         if (aluBus.isAluOp) begin
            case (aluBus.funct3)
               3'b000: acc <= aluBus.subtract ? diff[xlen-1:0] : sum;
               3'b010: acc <= {{(xlen-1){1'b0}}, lessSigned};    // SLT
               3'b011: acc <= {{(xlen-1){1'b0}}, lessUnsigned};  // SLTU
               3'b100: acc <= aluBus.in1 ^ aluBus.in2;
               3'b110: acc <= aluBus.in1 | aluBus.in2;
               3'b111: acc <= aluBus.in1 & aluBus.in2;
               default: begin                     // SLL, SRL, SRA
                  acc   <= aluBus.in1;
                  shamt <= aluBus.in2[4:0];
               end
            endcase
         end
      end else if (|shamt) begin
         shamt <= shamt - 5'd1;
         // funct3[2] picks right shift, arithShift fills with the sign
         acc <= aluBus.funct3[2] ? {aluBus.arithShift & acc[xlen-1], acc[xlen-1:1]}
                                 : {acc[xlen-2:0], 1'b0};
      end
   end

   // *******************************************************************
   // Branch predicate, latched one clock after start
   // *******************************************************************
   always_ff @(posedge clk) begin
      if (aluBus.start && !aluBus.isAluOp) begin
         case (aluBus.funct3)
            3'b000:  aluBus.predicate <= equal;          // BEQ
            3'b001:  aluBus.predicate <= !equal;         // BNE
            3'b100:  aluBus.predicate <= lessSigned;     // BLT
            3'b101:  aluBus.predicate <= !lessSigned;    // BGE
            3'b110:  aluBus.predicate <= lessUnsigned;   // BLTU
            3'b111:  aluBus.predicate <= !lessUnsigned;  // BGEU
            default: aluBus.predicate <= 1'b0;           // Not a branch code
         endcase
      end
   end

endmodule

// ==== rtl/aluIf.sv ====
`timescale 1ns/10ps

interface aluIf import rvPkg::*; ();

   logic [xlen-1:0] in1;          // rs1 value
   logic [xlen-1:0] in2;          // rs2 value or I immediate
   logic            start;        // One-cycle kick from the sequencer
   logic            isAluOp;      // High for ALU ops, low for branch tests
   funct3T          funct3;
   logic            subtract;     // SUB instead of ADD
   logic            arithShift;   // SRA instead of SRL
   logic [xlen-1:0] result;
   logic            predicate;    // Branch test, valid one clock after start
   logic            busy;         // Serial shift still running

   modport ctrl (
      output in1, in2, start, isAluOp, funct3, subtract, arithShift,
      input  result, predicate, busy
   );

   modport unit (
      input  in1, in2, start, isAluOp, funct3, subtract, arithShift,
      output result, predicate, busy
   );

endinterface

// ==== rtl/rvPkg.sv ====
package rvPkg;

   // *******************************************************************
   // Widths and fixed addresses
   // *******************************************************************
   localparam int xlen          = 32;   // Data word width
   localparam int addrWidth     = 24;   // Internal address bits, upper bus bits read zero
   localparam int regIndexWidth = 5;    // x0..x31

   localparam logic [addrWidth-1:0] resetAddr = '0;  // First fetch after reset

   // Either bit set puts an address in mapped device space
   localparam int ioBitHi = 23;
   localparam int ioBitLo = 22;

   typedef logic [2:0] funct3T;         // instr[14:12]

   // *******************************************************************
   // Major opcodes, keyed on instr[6:2]
   // *******************************************************************
   typedef enum logic [4:0] {
      opLoad   = 5'b00000,  // rd <- mem[rs1+Iimm]
      opAluImm = 5'b00100,  // rd <- rs1 OP Iimm
      opAuipc  = 5'b00101,  // rd <- PC + Uimm
      opStore  = 5'b01000,  // mem[rs1+Simm] <- rs2
      opAluReg = 5'b01100,  // rd <- rs1 OP rs2
      opLui    = 5'b01101,  // rd <- Uimm
      opBranch = 5'b11000,  // if (rs1 OP rs2) PC <- PC+Bimm
      opJalr   = 5'b11001,  // rd <- PC+4, PC <- rs1+Iimm
      opJal    = 5'b11011   // rd <- PC+4, PC <- PC+Jimm
   } opcodeT;

   // *******************************************************************
   // One-hot sequencer states
   // *******************************************************************
   typedef enum logic [7:0] {
      fetchInstr   = 8'b0000_0001,  // Address on bus, instruction in flight
      waitInstr    = 8'b0000_0010,  // Latch instruction once read is done
      fetchRegs    = 8'b0000_0100,  // Register values in flight
      execute      = 8'b0000_1000,  // Branch decision, next address
      loadData     = 8'b0001_0000,  // Load address on bus, data in flight
      waitAluOrMem = 8'b0010_0000,  // Shift in progress or bus busy
      storeData    = 8'b0100_0000,  // Write mask active for one cycle
      addrAndAlu   = 8'b1000_0000   // Address sum latched, ALU started
   } stateT;

   // Device accesses have to wait for the busy levels to drop
   function automatic logic ioSpace(input logic [addrWidth-1:0] addr);
      return addr[ioBitHi] | addr[ioBitLo];
   endfunction

endpackage
